// File: src/mshr_config.svh
`ifndef MSHR_CONFIG_SVH
`define MSHR_CONFIG_SVH

// MSHR table size
`define MSHR_ENTRY_NUM              16
`define MSHR_ID_WIDTH               4

// Pair FIFO holds 2**ADDR_WIDTH pairs
`define MSHR_PRE_ALLOC_ADDR_WIDTH   2

`endif

// File: src/mshr_pkg.sv
`default_nettype none

`include "mshr_config.svh"

package mshr_pkg;

    typedef logic [`MSHR_ID_WIDTH-1:0]  mshr_id_t;    // Entry id
    typedef logic [`MSHR_ENTRY_NUM-1:0] mshr_vec_t;   // One bit per entry

    // id_1 always holds the lower id
    typedef struct packed {
        mshr_id_t id_2;
        mshr_id_t id_1;
    } mshr_pair_t;

endpackage

`default_nettype wire

// File: src/mshr_free_table.sv
`default_nettype none

`include "mshr_config.svh"

module mshr_free_table
    import mshr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  mshr_vec_t claim_mask,
    input  logic      release_vld,
    input  mshr_id_t  release_id,
    output mshr_vec_t free_vec
);

    mshr_vec_t release_mask;
    mshr_vec_t free_vec_nxt;

    always_comb begin
        release_mask = '0;
        if (release_vld) begin
            release_mask[release_id] = 1'b1;   // Returned entry
        end
    end

    assign free_vec_nxt = (free_vec & ~claim_mask) | release_mask;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            free_vec <= {`MSHR_ENTRY_NUM{1'b1}};   // All entries free
        end else begin
            free_vec <= free_vec_nxt;
        end
    end

    // Consumer may only hand back entries it was given
    a_release_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        release_vld |-> !free_vec[release_id]
    ) else $error("release of free MSHR entry %0d", release_id);

    // Pre-allocator must only claim entries shown as free
    a_claim_free: assert property (
        @(posedge clk) disable iff (!arst_n)
        (claim_mask & ~free_vec) == '0
    ) else $error("claim of busy MSHR entry, mask %h", claim_mask);

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!arst_n)
        release_vld |-> !claim_mask[release_id]
    ) else $error("claim and release of MSHR entry %0d in one cycle", release_id);

endmodule

`default_nettype wire

// File: src/cmn_lead_two.sv
`default_nettype none

`include "mshr_config.svh"

module cmn_lead_two
    import mshr_pkg::*;
(
    input  mshr_vec_t v_entry_vld,
    output mshr_vec_t v_free_idx_oh_1,
    output mshr_id_t  v_free_idx_bin_1,
    output logic      v_free_vld_1,
    output mshr_vec_t v_free_idx_oh_2,
    output mshr_id_t  v_free_idx_bin_2,
    output logic      v_free_vld_2
);

    mshr_vec_t upper_vld;

    function automatic mshr_id_t oh_to_bin(input mshr_vec_t oh);
        mshr_id_t idx;
        idx = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if (oh[i]) begin
                idx = idx | mshr_id_t'(i);
            end
        end
        return idx;
    endfunction

    // Isolate lowest set bit
    assign v_free_idx_oh_1  = v_entry_vld & (~v_entry_vld + mshr_vec_t'(1));
    assign v_free_vld_1     = |v_entry_vld;
    assign v_free_idx_bin_1 = oh_to_bin(v_free_idx_oh_1);

    // Same again with the first hit removed
    assign upper_vld        = v_entry_vld & ~v_free_idx_oh_1;
    assign v_free_idx_oh_2  = upper_vld & (~upper_vld + mshr_vec_t'(1));
    assign v_free_vld_2     = |upper_vld;
    assign v_free_idx_bin_2 = oh_to_bin(v_free_idx_oh_2);

endmodule

`default_nettype wire

// File: src/fifo.sv
`default_nettype none

// Synchronous FIFO, first-word fall-through at dout.
// A write while full is dropped, even when a read happens in the same
// cycle, so a full FIFO only accepts new data one cycle after a pop.
module fifo #(
    parameter int unsigned DATA_WIDTH = 8,
    parameter int unsigned ADDR_WIDTH = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wr_ena,
    input  logic                  rd_ena,
    input  logic [DATA_WIDTH-1:0] din,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  full,
    output logic                  empty
);

    localparam int unsigned DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [ADDR_WIDTH:0]   wr_ptr;     // MSB is the wrap bit
    logic [ADDR_WIDTH:0]   rd_ptr;
    logic                  wr_ok;
    logic                  rd_ok;

    assign wr_ok = wr_ena && !full;
    assign rd_ok = rd_ena && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign dout = mem[rd_ptr[ADDR_WIDTH-1:0]];   // Head entry

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_ena |-> !empty
    ) else $error("fifo read while empty");

endmodule

`default_nettype wire

// File: src/pre_alloc_two.sv
`default_nettype none

`include "mshr_config.svh"

module pre_alloc_two
    import mshr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  mshr_vec_t  free_vec,
    output mshr_vec_t  claim_mask,
    output logic       out_vld,
    input  logic       out_rdy,
    output mshr_pair_t out_pair
);

    mshr_vec_t  free_oh_1;
    mshr_id_t   free_id_1;
    logic       free_vld_1;
    mshr_vec_t  free_oh_2;
    mshr_id_t   free_id_2;
    logic       free_vld_2;
    mshr_pair_t two_free_id;
    logic       pair_wr;
    logic       pair_rd;
    logic       buf_full;
    logic       buf_empty;

    cmn_lead_two i_cmn_lead_two (
        .v_entry_vld      (free_vec),
        .v_free_idx_oh_1  (free_oh_1),
        .v_free_idx_bin_1 (free_id_1),
        .v_free_vld_1     (free_vld_1),
        .v_free_idx_oh_2  (free_oh_2),
        .v_free_idx_bin_2 (free_id_2),
        .v_free_vld_2     (free_vld_2)
    );

    assign pair_wr = free_vld_1 && free_vld_2;   // FIFO drops it when full
    assign pair_rd = out_vld && out_rdy;

    // Claim only what the FIFO actually takes
    assign claim_mask = (pair_wr && !buf_full) ? (free_oh_1 | free_oh_2) : '0;

    assign two_free_id.id_1 = free_id_1;
    assign two_free_id.id_2 = free_id_2;

    fifo #(
        .DATA_WIDTH ($bits(mshr_pair_t)),
        .ADDR_WIDTH (`MSHR_PRE_ALLOC_ADDR_WIDTH)
    ) i_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .wr_ena (pair_wr),
        .rd_ena (pair_rd),
        .din    (two_free_id),
        .dout   (out_pair),
        .full   (buf_full),
        .empty  (buf_empty)
    );

    assign out_vld = !buf_empty;

    a_pair_order: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_vld |-> (out_pair.id_1 < out_pair.id_2)
    ) else $error("pair out of order %0d/%0d", out_pair.id_1, out_pair.id_2);

endmodule

`default_nettype wire

// File: src/mshr_alloc_top.sv
`default_nettype none

module mshr_alloc_top
    import mshr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       release_vld,
    input  mshr_id_t   release_id,
    output logic       alloc_vld,
    input  logic       alloc_rdy,
    output mshr_pair_t alloc_pair
);

    mshr_vec_t free_vec;
    mshr_vec_t claim_mask;

    mshr_free_table i_mshr_free_table (
        .clk         (clk),
        .arst_n      (arst_n),
        .claim_mask  (claim_mask),
        .release_vld (release_vld),
        .release_id  (release_id),
        .free_vec    (free_vec)
    );

    pre_alloc_two i_pre_alloc_two (
        .clk        (clk),
        .arst_n     (arst_n),
        .free_vec   (free_vec),
        .claim_mask (claim_mask),
        .out_vld    (alloc_vld),
        .out_rdy    (alloc_rdy),
        .out_pair   (alloc_pair)
    );

endmodule

`default_nettype wire

// File: test/tb_mshr_alloc.sv
`default_nettype none

`include "mshr_config.svh"

module tb_mshr_alloc
    import mshr_pkg::*;
();

    localparam int TIMEOUT     = 200;
    localparam int IDLE_WINDOW = 20;
    localparam int RAND_CYCLES = 400;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       release_vld;
    mshr_id_t   release_id;
    logic       alloc_vld;
    logic       alloc_rdy;
    mshr_pair_t alloc_pair;

    logic   owned [`MSHR_ENTRY_NUM];   // Popped and not yet released
    integer seed = 32'h5224;

    mshr_alloc_top i_mshr_alloc_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .release_vld (release_vld),
        .release_id  (release_id),
        .alloc_vld   (alloc_vld),
        .alloc_rdy   (alloc_rdy),
        .alloc_pair  (alloc_pair)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input int actual, input int expected, input string msg);
        if (actual != expected) begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s (got %0d, expected %0d)",
                                $time, msg, actual, expected));
        end
    endtask

    function automatic int owned_count();
        int cnt;
        cnt = 0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            cnt += int'(owned[i]);
        end
        return cnt;
    endfunction

    // Random start, then first owned id above it
    function automatic int pick_owned();
        int start;
        int idx;
        start = $random(seed) & (`MSHR_ENTRY_NUM - 1);
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            idx = (start + i) % `MSHR_ENTRY_NUM;
            if (owned[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic wait_for_vld(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!alloc_vld) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("Timeout: no valid pair for %s within %0d cycles",
                                    what, TIMEOUT));
            end
            @(negedge clk);
        end
    endtask

    // Caller holds alloc_rdy high
    task automatic pop_pair(output mshr_pair_t pair, input string what);
        wait_for_vld(what);
        pair = alloc_pair;
        @(posedge clk);   // Transfer edge
    endtask

    task automatic expect_pair(input mshr_pair_t pair, input int id_1, input int id_2);
        check_value(int'(pair.id_1), id_1, "pair id_1");
        check_value(int'(pair.id_2), id_2, "pair id_2");
    endtask

    task automatic record_pair(input mshr_pair_t pair);
        check_value(int'(pair.id_1 < pair.id_2), 1, "id_1 below id_2");
        check_value(int'(owned[pair.id_1]), 0, "id_1 handed out twice");
        check_value(int'(owned[pair.id_2]), 0, "id_2 handed out twice");
        owned[pair.id_1] = 1'b1;
        owned[pair.id_2] = 1'b1;
    endtask

    task automatic release_entry(input int id);
        check_value(int'(owned[id]), 1, "release of id not owned");
        @(posedge clk);
        release_vld <= 1'b1;
        release_id  <= mshr_id_t'(id);
        owned[id] = 1'b0;
        @(posedge clk);
        release_vld <= 1'b0;
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value(int'(alloc_vld), 0, "alloc_vld in idle window");
        end
    endtask

    task automatic test_reset_state();
        repeat (4) begin
            @(negedge clk);
            check_value(int'(alloc_vld), 0, "alloc_vld during reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        wait_for_vld("first pair after reset");
        expect_pair(alloc_pair, 0, 1);
    endtask

    task automatic test_drain_in_order();
        mshr_pair_t pair;
        @(posedge clk);
        alloc_rdy <= 1'b1;
        for (int k = 0; k < `MSHR_ENTRY_NUM / 2; k++) begin
            pop_pair(pair, "drain");
            expect_pair(pair, 2 * k, 2 * k + 1);
            record_pair(pair);
        end
        expect_idle(IDLE_WINDOW);   // Table is empty now
    endtask

    task automatic test_two_free_needed();
        mshr_pair_t pair;
        release_entry(9);
        expect_idle(IDLE_WINDOW);
        release_entry(5);
        pop_pair(pair, "pair of released ids");
        expect_pair(pair, 5, 9);
        record_pair(pair);
    endtask

    task automatic test_back_pressure();
        mshr_pair_t pair;
        mshr_pair_t head;
        @(posedge clk);
        alloc_rdy <= 1'b0;
        for (int id = 0; id < `MSHR_ENTRY_NUM; id++) begin
            release_entry(id);
        end
        wait_for_vld("head under back-pressure");
        head = alloc_pair;
        expect_pair(head, 0, 1);
        repeat (IDLE_WINDOW) begin
            @(negedge clk);
            check_value(int'(alloc_vld), 1, "alloc_vld held");
            check_value(int'(alloc_pair), int'(head), "alloc_pair stable");
        end
        @(posedge clk);
        alloc_rdy <= 1'b1;
        for (int k = 0; k < `MSHR_ENTRY_NUM / 2; k++) begin
            pop_pair(pair, "drain after back-pressure");
            expect_pair(pair, 2 * k, 2 * k + 1);
            record_pair(pair);
        end
    endtask

    task automatic test_random_traffic();
        mshr_pair_t pair;
        int id;
        int idle;
        logic drained;
        for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
            @(posedge clk);
            release_vld <= 1'b0;
            if (($random(seed) & 3) == 0) begin
                id = pick_owned();
                if (id >= 0) begin
                    release_vld <= 1'b1;
                    release_id  <= mshr_id_t'(id);
                    owned[id] = 1'b0;
                end
            end
            alloc_rdy <= ($random(seed) & 1) != 0;
            @(negedge clk);
            if (alloc_vld && alloc_rdy) begin
                pair = alloc_pair;   // Taken at the next edge
                record_pair(pair);
            end
        end
        @(posedge clk);
        release_vld <= 1'b0;
        alloc_rdy   <= 1'b0;   // No pops while the odd entry goes back
        if (owned_count() % 2 != 0) begin
            release_entry(pick_owned());   // A lone free entry never pairs up
        end
        @(posedge clk);
        alloc_rdy <= 1'b1;
        drained = 1'b0;
        while (!drained) begin
            idle = 0;
            @(negedge clk);
            while (!alloc_vld && idle < IDLE_WINDOW) begin
                idle++;
                @(negedge clk);
            end
            if (alloc_vld) begin
                pair = alloc_pair;
                record_pair(pair);
                @(posedge clk);   // Transfer edge
            end else begin
                drained = 1'b1;
            end
        end
        check_value(owned_count(), `MSHR_ENTRY_NUM, "owned ids after drain");
        expect_idle(IDLE_WINDOW);
    endtask

    initial begin
        arst_n      = 1'b0;
        release_vld = 1'b0;
        release_id  = '0;
        alloc_rdy   = 1'b0;
        foreach (owned[i]) begin
            owned[i] = 1'b0;
        end
        test_reset_state();
        test_drain_in_order();
        test_two_free_needed();
        test_back_pressure();
        test_random_traffic();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/mshr_pkg.sv
src/mshr_free_table.sv
src/cmn_lead_two.sv
src/fifo.sv
src/pre_alloc_two.sv
src/mshr_alloc_top.sv
test/tb_mshr_alloc.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mshr_alloc
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
